// File: hdl/gamePkg.sv
// shared types and constants for the scene compositor
// coordinates are 10-bit unsigned, so all geometry must stay below 1024
// every object is a flat palette colour, no sprite bitmaps
// lives are tracked against a single pipe at a fixed position
`default_nettype none

package gamePkg;

    // ----------------------------------------------------------------------
    // basic types
    // ----------------------------------------------------------------------
    typedef logic [9:0] coord_t;
    typedef logic [7:0] colour_t;

    typedef struct packed {
        colour_t red;
        colour_t green;
        colour_t blue;
    } rgb_t;

    // ----------------------------------------------------------------------
    // palette
    // ----------------------------------------------------------------------
    localparam int PaletteSize = 8;

    localparam rgb_t Palette [PaletteSize] = '{
        24'h00FF44,
        24'hFFDDEE,
        24'hCC7711,
        24'hDD00FF,
        24'h662255,
        24'h662266,
        24'h000000,
        24'hAAAAAA
    };

    localparam int BallColourIdx  = 3;
    localparam int PipeColourIdx  = 0;
    localparam int HeartColourIdx = 2;

    localparam rgb_t BackgroundRgb = 24'h0000FF;

    // ----------------------------------------------------------------------
    // scene geometry
    // ----------------------------------------------------------------------
    localparam coord_t PipeX      = 10'd300;
    localparam coord_t PipeY      = 10'd380;
    localparam coord_t PipeWidth  = 10'd50;
    localparam coord_t PipeHeight = 10'd100;

    localparam int     HeartCount = 3;
    localparam coord_t HeartX0    = 10'd450;
    localparam coord_t HeartPitch = 10'd50;
    localparam coord_t HeartY     = 10'd20;
    localparam coord_t HeartSize  = 10'd50;

    // ball corner to the point tested against the pipe
    localparam coord_t CollisionProbeOffset = 10'd30;

    // ----------------------------------------------------------------------
    // lives
    // ----------------------------------------------------------------------
    typedef enum logic [2:0] {
        LivesFull,
        HitFirst,
        LivesTwo,
        HitSecond,
        LivesOne,
        LivesNone
    } livesState_t;

    // bit i set while heart i is still drawn
    typedef logic [HeartCount-1:0] heartMask_t;

endpackage

`default_nettype wire

// File: hdl/sceneLayersIf.sv
// registered layer hits between the two pixel stages
// no handshake, one pixel per cycle, all bits valid together
`timescale 1ns/10ps
`default_nettype none

interface sceneLayersIf;

    logic BallOn;
    logic PipeOn;
    logic HeartOn;
    // blank input delayed with the hits
    logic Visible;

    modport source
    (
        output BallOn,
        output PipeOn,
        output HeartOn,
        output Visible
    );

    modport sink
    (
        input BallOn,
        input PipeOn,
        input HeartOn,
        input Visible
    );

endinterface

`default_nettype wire

// File: hdl/livesTracker.sv
// collision FSM for the ball against the single pipe
// a collision is the probe point strictly inside the pipe box
// after a hit the ball must clear the pipe's right edge before the
// next hit counts, so one pass through the pipe costs one life
// outputs follow the state register, one cycle after the ball input
`timescale 1ns/10ps
`default_nettype none

module livesTracker
    import gamePkg::*;
(
    input  logic       Clk,
    input  logic       Reset,
    input  coord_t     BallX,
    input  coord_t     BallY,
    output heartMask_t HeartsIntact,
    output logic [1:0] Lives
);

    livesState_t state;
    livesState_t stateNext;

    // one extra bit so the sums never wrap
    logic [10:0] probeX;
    logic [10:0] probeY;
    logic [10:0] pipeRight;
    logic [10:0] pipeBottom;
    logic        collision;
    logic        pastPipe;

    assign probeX     = {1'b0, BallX} + {1'b0, CollisionProbeOffset};
    assign probeY     = {1'b0, BallY} + {1'b0, CollisionProbeOffset};
    assign pipeRight  = {1'b0, PipeX} + {1'b0, PipeWidth};
    assign pipeBottom = {1'b0, PipeY} + {1'b0, PipeHeight};

    assign collision = (probeX > {1'b0, PipeX}) && (probeX < pipeRight) &&
                       (probeY > {1'b0, PipeY}) && (probeY < pipeBottom);
    assign pastPipe  = {1'b0, BallX} > pipeRight;

    // ----------------------------------------------------------------------
    // state machine
    // ----------------------------------------------------------------------
    always_comb
    begin
        stateNext = state;
        case (state)
            LivesFull: if (collision) stateNext = HitFirst;
            HitFirst:  if (pastPipe)  stateNext = LivesTwo;
            LivesTwo:  if (collision) stateNext = HitSecond;
            HitSecond: if (pastPipe)  stateNext = LivesOne;
            LivesOne:  if (collision) stateNext = LivesNone;
            LivesNone: stateNext = LivesNone;
            default:   stateNext = LivesFull;
        endcase
    end

    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
            state <= LivesFull;
        else
            state <= stateNext;
    end

    // ----------------------------------------------------------------------
    // lives count and heart mask
    // ----------------------------------------------------------------------
    always_comb
    begin
        case (state)
            LivesFull: Lives = 2'd3;
            HitFirst:  Lives = 2'd2;
            LivesTwo:  Lives = 2'd2;
            HitSecond: Lives = 2'd1;
            LivesOne:  Lives = 2'd1;
            default:   Lives = 2'd0;
        endcase
    end

    // hearts are lost from bit 0 upward
    for (genvar i = 0; i < HeartCount; i++)
    begin : gHeartMask
        assign HeartsIntact[i] = Lives > 2'(HeartCount - 1 - i);
    end

    livesNeverRise: assert property (
        @(posedge Clk) disable iff (Reset) Lives <= $past(Lives)
    ) else $error("lives count rose without reset");

endmodule

`default_nettype wire

// File: hdl/sceneLocator.sv
// first pixel stage: rectangle tests for ball, pipe and hearts
// all boxes are half-open, [start, start + size)
// a heart only hits while its bit in HeartsIntact is set
// hits and Blank are registered, one cycle of latency
`timescale 1ns/10ps
`default_nettype none

module sceneLocator
    import gamePkg::*;
(
    input  logic         Clk,
    input  logic         Reset,
    input  coord_t       DrawX,
    input  coord_t       DrawY,
    input  logic         Blank,
    input  coord_t       BallX,
    input  coord_t       BallY,
    input  coord_t       BallSize,
    input  heartMask_t   HeartsIntact,
    sceneLayersIf.source Layers
);

    logic ballHit;
    logic pipeHit;
    logic heartHit;

    // widened so start + size cannot wrap
    function automatic logic inSpan(coord_t pos, coord_t start, coord_t size);
        logic [10:0] last;
        last = {1'b0, start} + {1'b0, size};
        return ({1'b0, pos} >= {1'b0, start}) && ({1'b0, pos} < last);
    endfunction

    assign ballHit = inSpan(DrawX, BallX, BallSize) && inSpan(DrawY, BallY, BallSize);
    assign pipeHit = inSpan(DrawX, PipeX, PipeWidth) && inSpan(DrawY, PipeY, PipeHeight);

    // heart row, one box per heart
    always_comb
    begin
        heartHit = 1'b0;
        for (int i = 0; i < HeartCount; i++)
        begin
            if (HeartsIntact[i] &&
                inSpan(DrawX, HeartX0 + coord_t'(i) * HeartPitch, HeartSize) &&
                inSpan(DrawY, HeartY, HeartSize))
            begin
                heartHit = 1'b1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // stage register
    // ----------------------------------------------------------------------
    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
        begin
            Layers.BallOn  <= 1'b0;
            Layers.PipeOn  <= 1'b0;
            Layers.HeartOn <= 1'b0;
            Layers.Visible <= 1'b0;
        end
        else
        begin
            Layers.BallOn  <= ballHit;
            Layers.PipeOn  <= pipeHit;
            Layers.HeartOn <= heartHit;
            Layers.Visible <= Blank;
        end
    end

endmodule

`default_nettype wire

// File: hdl/paletteMapper.sv
// second pixel stage: fixed priority and palette lookup
// priority is blanking, ball, pipe, heart, then background
// output colour is registered, one cycle of latency
`timescale 1ns/10ps
`default_nettype none

module paletteMapper
    import gamePkg::*;
(
    input  logic       Clk,
    input  logic       Reset,
    sceneLayersIf.sink Layers,
    output colour_t    Red,
    output colour_t    Green,
    output colour_t    Blue
);

    rgb_t pixelRgb;
    rgb_t outRgb;

    always_comb
    begin
        if (!Layers.Visible)
            pixelRgb = '0;
        else if (Layers.BallOn)
            pixelRgb = Palette[BallColourIdx];
        else if (Layers.PipeOn)
            pixelRgb = Palette[PipeColourIdx];
        else if (Layers.HeartOn)
            pixelRgb = Palette[HeartColourIdx];
        else
            pixelRgb = BackgroundRgb;
    end

    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
            outRgb <= '0;
        else
            outRgb <= pixelRgb;
    end

    assign Red   = outRgb.red;
    assign Green = outRgb.green;
    assign Blue  = outRgb.blue;

    // blanked pixel must come out black on the next cycle
    blankGivesBlack: assert property (
        @(posedge Clk) disable iff (Reset)
        !Layers.Visible |=> (Red == '0) && (Green == '0) && (Blue == '0)
    ) else $error("blanked pixel produced a colour");

endmodule

`default_nettype wire

// File: hdl/sceneRenderer.sv
// scene compositor top level
// DrawX, DrawY and Blank reach Red, Green and Blue two cycles later
// Blank is high during the visible area
// Lives follows the ball inputs by one cycle
`timescale 1ns/10ps
`default_nettype none

module sceneRenderer
    import gamePkg::*;
(
    input  logic       Clk,
    input  logic       Reset,
    input  coord_t     DrawX,
    input  coord_t     DrawY,
    input  logic       Blank,
    input  coord_t     BallX,
    input  coord_t     BallY,
    input  coord_t     BallSize,
    output colour_t    Red,
    output colour_t    Green,
    output colour_t    Blue,
    output logic [1:0] Lives
);

    heartMask_t   heartsIntact;
    sceneLayersIf layers ();

    livesTracker u_livesTracker
    (
        .Clk          (Clk),
        .Reset        (Reset),
        .BallX        (BallX),
        .BallY        (BallY),
        .HeartsIntact (heartsIntact),
        .Lives        (Lives)
    );

    sceneLocator u_sceneLocator
    (
        .Clk          (Clk),
        .Reset        (Reset),
        .DrawX        (DrawX),
        .DrawY        (DrawY),
        .Blank        (Blank),
        .BallX        (BallX),
        .BallY        (BallY),
        .BallSize     (BallSize),
        .HeartsIntact (heartsIntact),
        .Layers       (layers.source)
    );

    paletteMapper u_paletteMapper
    (
        .Clk    (Clk),
        .Reset  (Reset),
        .Layers (layers.sink),
        .Red    (Red),
        .Green  (Green),
        .Blue   (Blue)
    );

endmodule

`default_nettype wire

// File: include/sceneModel.svh
// reference model functions for the testbench
// include inside a module that imports gamePkg
// pure functions only
// the caller keeps the state and the delay queues
`ifndef SCENE_MODEL_SVH
`define SCENE_MODEL_SVH

// probe point strictly inside the pipe box
function automatic bit probeInPipe(coord_t ballX, coord_t ballY);
    int px;
    int py;
    px = int'(ballX) + int'(CollisionProbeOffset);
    py = int'(ballY) + int'(CollisionProbeOffset);
    return (px > int'(PipeX)) && (px < int'(PipeX) + int'(PipeWidth)) &&
           (py > int'(PipeY)) && (py < int'(PipeY) + int'(PipeHeight));
endfunction

function automatic livesState_t nextLivesState(livesState_t state, coord_t ballX,
                                               coord_t ballY);
    bit hit;
    bit past;
    hit  = probeInPipe(ballX, ballY);
    past = int'(ballX) > int'(PipeX) + int'(PipeWidth);
    case (state)
        LivesFull: return hit  ? HitFirst  : LivesFull;
        HitFirst:  return past ? LivesTwo  : HitFirst;
        LivesTwo:  return hit  ? HitSecond : LivesTwo;
        HitSecond: return past ? LivesOne  : HitSecond;
        LivesOne:  return hit  ? LivesNone : LivesOne;
        default:   return LivesNone;
    endcase
endfunction

function automatic logic [1:0] livesOfState(livesState_t state);
    case (state)
        LivesFull:          return 2'd3;
        HitFirst, LivesTwo: return 2'd2;
        HitSecond, LivesOne: return 2'd1;
        default:            return 2'd0;
    endcase
endfunction

// every lost life removes the lowest heart still drawn
function automatic heartMask_t heartsOfState(livesState_t state);
    heartMask_t mask;
    int         lost;
    lost = HeartCount - int'(livesOfState(state));
    for (int i = 0; i < HeartCount; i++)
        mask[i] = i >= lost;
    return mask;
endfunction

function automatic bit insideBox(coord_t x, coord_t y, int bx, int by, int w, int h);
    return (int'(x) >= bx) && (int'(x) < bx + w) && (int'(y) >= by) && (int'(y) < by + h);
endfunction

function automatic rgb_t expectedPixel(coord_t drawX, coord_t drawY, logic blank,
                                       coord_t ballX, coord_t ballY, coord_t ballSize,
                                       heartMask_t hearts);
    bit heartHit;
    heartHit = 1'b0;
    for (int i = 0; i < HeartCount; i++)
    begin
        if (hearts[i] && insideBox(drawX, drawY, int'(HeartX0) + i * int'(HeartPitch),
                                   int'(HeartY), int'(HeartSize), int'(HeartSize)))
            heartHit = 1'b1;
    end
    if (!blank)
        return '0;
    if (insideBox(drawX, drawY, int'(ballX), int'(ballY), int'(ballSize), int'(ballSize)))
        return Palette[BallColourIdx];
    if (insideBox(drawX, drawY, int'(PipeX), int'(PipeY), int'(PipeWidth), int'(PipeHeight)))
        return Palette[PipeColourIdx];
    if (heartHit)
        return Palette[HeartColourIdx];
    return BackgroundRgb;
endfunction

`endif

// File: tb/sceneRendererTb.sv
// testbench for sceneRenderer
// random pixels and ball paths from a fixed seed
// results are checked against the reference model in sceneModel.svh
// outputs and Lives are sampled on the falling edge where they are stable
`timescale 1ns/10ps
`default_nettype none

module sceneRendererTb
    import gamePkg::*;
();

    localparam int ClkPeriod       = 8;
    localparam int ResetCycles     = 8;
    localparam int ParkCycles      = 600;
    localparam int HoldCycles      = 40;
    localparam int PassCycles      = 10;
    localparam int SweepPixels     = 4;
    localparam int LivesWaitCycles = 8;
    localparam int TailCycles      = 200;
    localparam int RandomCycles    = 2000;
    localparam int BallHoldCycles  = 16;
    localparam int SweepCycles     = SweepPixels * HeartCount;
    localparam int StimulusCycles  = 2 * (ResetCycles + 2) + SweepCycles + ParkCycles +
                                     LivesWaitCycles + HoldCycles + TailCycles +
                                     3 * (LivesWaitCycles + PassCycles + SweepCycles) +
                                     RandomCycles + 8;
    localparam int MarginCycles    = 200;

    logic       Clk;
    logic       Reset;
    coord_t     DrawX;
    coord_t     DrawY;
    logic       Blank;
    coord_t     BallX;
    coord_t     BallY;
    coord_t     BallSize;
    colour_t    Red;
    colour_t    Green;
    colour_t    Blue;
    logic [1:0] Lives;

    int          errorCount;
    int          checkCount;
    int          testCount;
    int          errorsAtTestStart;
    livesState_t modelState;
    rgb_t        expectedQ[$];

    `include "sceneModel.svh"

    sceneRenderer DUT
    (
        .Clk      (Clk),
        .Reset    (Reset),
        .DrawX    (DrawX),
        .DrawY    (DrawY),
        .Blank    (Blank),
        .BallX    (BallX),
        .BallY    (BallY),
        .BallSize (BallSize),
        .Red      (Red),
        .Green    (Green),
        .Blue     (Blue),
        .Lives    (Lives)
    );

    initial
    begin
        Clk = 1'b0;
        forever #(ClkPeriod / 2) Clk = ~Clk;
    end

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------
    function automatic int randomInRange(int lo, int hi);
        return lo + int'($urandom % 32'(hi - lo + 1));
    endfunction

    task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
        checkCount++;
        if (expected !== actual)
        begin
            errorCount++;
            $display("CHECK FAILED at %0d ns: %s expected %0h got %0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic finishTest(string name);
        testCount++;
        $display("test %0d %s: %0d errors", testCount, name, errorCount - errorsAtTestStart);
        errorsAtTestStart = errorCount;
    endtask

    task automatic applyReset();
        @(posedge Clk);
        Reset <= 1'b1;
        repeat (ResetCycles) @(posedge Clk);
        Reset <= 1'b0;
    endtask

    // one pixel per cycle
    // heart >= 0 forces a visible pixel in that heart
    task automatic driveCycle(int bx, int by, int bs, int heart);
        int   kind;
        int   px;
        int   py;
        logic blankNext;
        kind      = randomInRange(0, 3);
        blankNext = randomInRange(0, 3) != 0;
        if (heart >= 0)
        begin
            px = int'(HeartX0) + heart * int'(HeartPitch) +
                 randomInRange(0, int'(HeartSize) - 1);
            py = int'(HeartY) + randomInRange(0, int'(HeartSize) - 1);
            blankNext = 1'b1;
        end
        else if (kind == 0)
        begin
            px = randomInRange(0, 639);
            py = randomInRange(0, 479);
        end
        else if (kind == 1)
        begin
            px = randomInRange(bx > 10 ? bx - 10 : 0, bx + bs + 10);
            py = randomInRange(by > 10 ? by - 10 : 0, by + bs + 10);
        end
        else if (kind == 2)
        begin
            px = randomInRange(290, 360);
            py = randomInRange(370, 490);
        end
        else
        begin
            px = randomInRange(440, 610);
            py = randomInRange(10, 80);
        end
        @(posedge Clk);
        BallX    <= coord_t'(bx);
        BallY    <= coord_t'(by);
        BallSize <= coord_t'(bs);
        DrawX    <= coord_t'(px);
        DrawY    <= coord_t'(py);
        Blank    <= blankNext;
    endtask

    task automatic sweepHearts(int bx, int by, int bs);
        for (int i = 0; i < HeartCount; i++)
            repeat (SweepPixels) driveCycle(bx, by, bs, i);
    endtask

    // keep the ball in place until Lives reaches the target
    task automatic holdUntilLives(int bx, int by, int bs, logic [1:0] target);
        int waited;
        bit reached;
        waited  = 0;
        reached = 1'b0;
        while (!reached && waited < LivesWaitCycles)
        begin
            driveCycle(bx, by, bs, -1);
            @(negedge Clk);
            reached = (Lives == target);
            waited++;
        end
        if (!reached)
        begin
            errorCount++;
            $display("ERROR at %0d ns: Lives did not reach %0d within %0d cycles",
                     $time, target, LivesWaitCycles);
        end
    endtask

    // ----------------------------------------------------------------------
    // model and output checks
    // ----------------------------------------------------------------------
    // output seen here belongs to the pixel sampled two edges back
    always @(negedge Clk)
    begin
        rgb_t expected;
        if (Reset)
        begin
            modelState = LivesFull;
            expectedQ.delete();
            expectedQ.push_back('0);
            expectedQ.push_back('0);
        end
        else
        begin
            checkValue("Lives", 32'(livesOfState(modelState)), {30'd0, Lives});
            expected = expectedQ.pop_front();
            checkValue("RGB", {8'h00, expected}, {8'h00, Red, Green, Blue});
            expectedQ.push_back(expectedPixel(DrawX, DrawY, Blank, BallX, BallY, BallSize,
                                              heartsOfState(modelState)));
            modelState = nextLivesState(modelState, BallX, BallY);
        end
    end

    initial
    begin
        #((StimulusCycles + MarginCycles) * ClkPeriod);
        $display("watchdog: run did not finish within %0d cycles",
                 StimulusCycles + MarginCycles);
        $display("FAIL: see errors above");
        $finish;
    end

    // ----------------------------------------------------------------------
    // tests
    // ----------------------------------------------------------------------
    initial
    begin
        int bx;
        int by;
        int bs;
        void'($urandom(32'h2ce8bc1b));
        errorCount        = 0;
        checkCount        = 0;
        testCount         = 0;
        errorsAtTestStart = 0;
        Reset    = 1'b1;
        DrawX    = '0;
        DrawY    = '0;
        Blank    = 1'b0;
        BallX    = coord_t'(100);
        BallY    = coord_t'(100);
        BallSize = coord_t'(30);

        applyReset();
        @(negedge Clk);
        checkValue("RGB after reset", 32'd0, {8'h00, Red, Green, Blue});
        checkValue("Lives after reset", 32'd3, {30'd0, Lives});
        sweepHearts(100, 100, 30);
        finishTest("reset and full hearts");

        // ball parked away from the pipe for the first half
        // second half overlaps the pipe without a collision
        bs = randomInRange(16, 96);
        for (int n = 0; n < ParkCycles; n++)
        begin
            if (n < ParkCycles / 2)
                driveCycle(100, 100, bs, -1);
            else
                driveCycle(250, 330, 80, -1);
        end
        finishTest("parked ball pixels");

        holdUntilLives(290, 370, 40, 2'd2);
        repeat (HoldCycles) driveCycle(290, 370, 40, -1);
        @(negedge Clk);
        checkValue("Lives while held in pipe", 32'd2, {30'd0, Lives});
        finishTest("first collision");

        // clear the pipe and check the hearts before the next collision
        for (int lives = 2; lives > 0; lives--)
        begin
            repeat (PassCycles) driveCycle(360, 370, 40, -1);
            sweepHearts(360, 370, 40);
            holdUntilLives(290, 370, 40, 2'(lives - 1));
        end
        sweepHearts(290, 370, 40);
        repeat (TailCycles) driveCycle(randomInRange(200, 400), randomInRange(300, 460), 40, -1);
        @(negedge Clk);
        checkValue("Lives after last heart", 32'd0, {30'd0, Lives});
        finishTest("lives run down and lost hearts");

        applyReset();
        bx = 100;
        by = 100;
        bs = 30;
        for (int n = 0; n < RandomCycles; n++)
        begin
            if (n % BallHoldCycles == 0)
            begin
                bx = randomInRange(200, 400);
                by = randomInRange(300, 460);
                bs = randomInRange(16, 80);
            end
            driveCycle(bx, by, bs, -1);
        end
        repeat (4) driveCycle(bx, by, bs, -1);
        @(negedge Clk);
        finishTest("random ball paths");

        $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
        if (errorCount == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
hdl/gamePkg.sv
hdl/sceneLayersIf.sv
hdl/livesTracker.sv
hdl/sceneLocator.sv
hdl/paletteMapper.sv
hdl/sceneRenderer.sv
tb/sceneRendererTb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the scene renderer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module sceneRendererTb -f verilog.f

output=$(./obj_dir/VsceneRendererTb)
echo "$output"

if echo "$output" | grep -qx "PASS: all tests"; then
    exit 0
fi
exit 1
